// File: all.f
+incdir+hw
+incdir+tests
hw/ntm_pkg.sv
hw/dot_product_accumulator.sv
hw/logistic_function.sv
hw/forget_gate_vector.sv
hw/forget_gate_top.sv
tests/tb_forget_gate.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the forget-gate testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module tb_forget_gate \
  --Mdir obj_dir \
  -o tb_forget_gate

./obj_dir/tb_forget_gate | tee "$LOG"

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
else
  exit 1
fi

// File: tests/tb_forget_gate_model.svh
/*
 * Forget-gate reference model
 * Q16.16 product, piecewise-linear sigmoid and row result
 */

`ifndef TB_FORGET_GATE_MODEL_SVH
`define TB_FORGET_GATE_MODEL_SVH

//////////////////////////////
// Fixed-point helpers

// Exact for the binary fractions used here
function automatic fixed_t to_fixed(input real r);
  return fixed_t'(longint'(r * (2.0 ** `NTM_FRAC_BITS)));
endfunction

// Full product, arithmetic shift, low 32 bits kept
function automatic fixed_t model_mul(input fixed_t a, input fixed_t b);
  longint p;
  p = longint'(a) * longint'(b);
  return fixed_t'(p >>> `NTM_FRAC_BITS);
endfunction

// slope*a + offset, product floored
function automatic longint segment(input longint a, input real slope, input real offset);
  return ((a * longint'(to_fixed(slope))) >>> `NTM_FRAC_BITS) + longint'(to_fixed(offset));
endfunction

//////////////////////////////
// Sigmoid

function automatic fixed_t model_sigmoid(input fixed_t z);
  longint a;
  longint f;
  a = (z < 0) ? -longint'(z) : longint'(z);  // 64 bits, so -2^31 is safe
  if (a >= longint'(to_fixed(5.0)))        f = longint'(to_fixed(1.0));
  else if (a >= longint'(to_fixed(2.375))) f = segment(a, 0.03125, 0.84375);
  else if (a >= longint'(to_fixed(1.0)))   f = segment(a, 0.125, 0.625);
  else                                     f = segment(a, 0.25, 0.5);
  if (z < 0) f = longint'(to_fixed(1.0)) - f;  // Mirror about 0.5
  return fixed_t'(f);
endfunction

// Dot-product sum plus bias, wrapping in 32 bits
function automatic fixed_t model_row(input fixed_t sum, input fixed_t bias);
  fixed_t z;
  z = sum + bias;
  return model_sigmoid(z);
endfunction

`endif

// File: tests/tb_forget_gate.sv
/*
 * Forget-gate vector unit testbench
 * Random and directed jobs against a Q16.16 reference model, with
 * output value, output timing and READY checked by concurrent assertions
 */

`timescale 1ns/1ns

`include "ntm_config.svh"

module tb_forget_gate import ntm_pkg::*; ();

  //////////////////////////////
  // Jobs and run limit

  localparam gate_sizes_t JOB_A    = '{size_x: 8'd3, size_w: 8'd2, size_l: 8'd2, size_r: 8'd1};
  localparam gate_sizes_t JOB_B    = '{size_x: 8'd0, size_w: 8'd5, size_l: 8'd9, size_r: 8'd0};
  localparam gate_sizes_t JOB_C    = '{size_x: 8'd2, size_w: 8'd2, size_l: 8'd4, size_r: 8'd2};
  localparam gate_sizes_t JOB_D    = '{size_x: 8'd3, size_w: 8'd4, size_l: 8'd3, size_r: 8'd0};
  localparam gate_sizes_t JOB_BUSY = '{size_x: 8'd1, size_w: 8'd1, size_l: 8'd1, size_r: 8'd1};

  // Pairs plus bias strobes of one job
  function automatic int job_ops(input gate_sizes_t s);
    return int'(s.size_l) * (int'(s.size_x) + int'(s.size_r) * int'(s.size_w) +
                             int'(s.size_l) + 1);
  endfunction

  localparam int TIMEOUT_CYCLES =
    2 * (job_ops(JOB_A) + job_ops(JOB_B) + job_ops(JOB_C) + job_ops(JOB_D)) + 200;

  `include "tb_forget_gate_model.svh"

  //////////////////////////////
  // DUT and bench state

  logic          CLK, RST, START;
  gate_sizes_t   SIZE_IN;
  logic          PAIR_IN_ENABLE, B_IN_ENABLE;
  operand_pair_t PAIR_IN;
  fixed_t        B_IN;
  logic          F_OUT_ENABLE, READY;
  fixed_t        F_OUT;

  typedef struct packed {
    fixed_t      value;
    logic [31:0] due;   // Cycle whose F_OUT_ENABLE carries it
    logic        last;  // Last row of its job brings READY as well
  } expect_t;

  expect_t expect_q[$];
  int      cycle   = 0;  // Rising edges so far
  integer  seed    = 32'h174edcc8;
  logic    started = 1'b0;  // First START driven
  logic    want_en, want_ready;
  fixed_t  want_val;

  forget_gate_top dut_i (
    .CLK(CLK), .RST(RST),
    .START(START), .SIZE_IN(SIZE_IN),
    .PAIR_IN_ENABLE(PAIR_IN_ENABLE), .PAIR_IN(PAIR_IN),
    .B_IN_ENABLE(B_IN_ENABLE), .B_IN(B_IN),
    .F_OUT_ENABLE(F_OUT_ENABLE), .F_OUT(F_OUT), .READY(READY)
  );

  always #20 CLK = ~CLK;  // 40 ns period

  always @(posedge CLK) cycle <= cycle + 1;

  //////////////////////////////
  // Scoreboard

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  // Expected outputs held through the cycle just begun
  always @(negedge CLK) begin
    want_en    = 1'b0;
    want_ready = 1'b0;
    if (expect_q.size() != 0 && expect_q[0].due == cycle) begin
      want_en    = 1'b1;
      want_val   = expect_q[0].value;
      want_ready = expect_q[0].last;
      void'(expect_q.pop_front());
    end
  end

  a_out_enable: assert property (@(posedge CLK) disable iff (RST) F_OUT_ENABLE == want_en)
    else begin
      $display("** Error: F_OUT_ENABLE = %h, expected %h", F_OUT_ENABLE, want_en);
      stop_on_error();
    end

  a_out_value: assert property (@(posedge CLK) disable iff (RST)
                                F_OUT_ENABLE |-> F_OUT == want_val)
    else begin
      $display("** Error: F_OUT = %h, expected %h", F_OUT, want_val);
      stop_on_error();
    end

  a_ready: assert property (@(posedge CLK) disable iff (RST) READY == want_ready)
    else begin
      $display("** Error: READY = %h, expected %h", READY, want_ready);
      stop_on_error();
    end

  a_quiet: assert property (@(posedge CLK) disable iff (RST) !started |-> F_OUT == '0)
    else begin
      $display("** Error: F_OUT = %h, expected %h", F_OUT, 32'h0);
      stop_on_error();
    end

  always @(posedge CLK) begin
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: outputs still missing after %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  //////////////////////////////
  // Stimulus, all on the falling edge

  function automatic fixed_t rand_fixed();
    integer r;
    r = $random(seed);
    return fixed_t'(r % 262145);  // Within +-4.0
  endfunction

  task automatic idle_cycle();
    @(negedge CLK);
    START          = 1'b0;
    PAIR_IN_ENABLE = 1'b0;
    B_IN_ENABLE    = 1'b0;
    PAIR_IN        = '{weight: rand_fixed(), value: rand_fixed()};  // Unstrobed junk
    B_IN           = rand_fixed();
  endtask

  task automatic random_gap();
    if ($random(seed) & 1) idle_cycle();
  endtask

  task automatic strobe_start(input gate_sizes_t s);
    @(negedge CLK);
    PAIR_IN_ENABLE = 1'b0;
    B_IN_ENABLE    = 1'b0;
    START          = 1'b1;
    SIZE_IN        = s;
    started        = 1'b1;
  endtask

  task automatic strobe_pair(input fixed_t w, input fixed_t v);
    @(negedge CLK);
    START          = 1'b0;
    B_IN_ENABLE    = 1'b0;
    PAIR_IN_ENABLE = 1'b1;
    PAIR_IN        = '{weight: w, value: v};
  endtask

  task automatic strobe_bias(input fixed_t b);
    @(negedge CLK);
    START          = 1'b0;
    PAIR_IN_ENABLE = 1'b0;
    B_IN_ENABLE    = 1'b1;
    B_IN           = b;
  endtask

  // Called in the cycle that drives the bias
  task automatic expect_row(input fixed_t value, input logic last);
    expect_t e;
    e.value = value;
    e.due   = cycle + 3;  // MAC, sigmoid, output registers
    e.last  = last;
    expect_q.push_back(e);
  endtask

  // Exact piecewise values for the sigmoid segment sweep
  task automatic sweep_point(input int idx, output fixed_t b, output fixed_t e);
    case (idx)
      0:       begin b = to_fixed(-6.0); e = to_fixed(0.0);    end  // Low saturation
      1:       begin b = to_fixed(-3.0); e = to_fixed(0.0625); end
      2:       begin b = to_fixed(-1.5); e = to_fixed(0.1875); end
      3:       begin b = to_fixed(-0.5); e = to_fixed(0.375);  end
      4:       begin b = to_fixed(0.0);  e = to_fixed(0.5);    end  // Centre
      5:       begin b = to_fixed(0.5);  e = to_fixed(0.625);  end
      6:       begin b = to_fixed(1.5);  e = to_fixed(0.8125); end
      7:       begin b = to_fixed(3.0);  e = to_fixed(0.9375); end
      default: begin b = to_fixed(6.0);  e = to_fixed(1.0);    end  // High saturation
    endcase
  endtask

  // One job with rows in order of X pairs, R*W pairs, L pairs and bias
  task automatic run_job(input gate_sizes_t s, input logic gaps, input logic disturb,
                         input logic sweep);
    fixed_t sum, w, v, b, e;
    int     n_pairs;
    n_pairs = int'(s.size_x) + int'(s.size_r) * int'(s.size_w) + int'(s.size_l);
    strobe_start(s);
    for (int row = 0; row < int'(s.size_l); row++) begin
      sum = '0;
      for (int k = 0; k < n_pairs; k++) begin
        if (gaps) random_gap();
        w   = sweep ? fixed_t'(0) : rand_fixed();  // Zero weights leave the bias alone
        v   = rand_fixed();
        sum = sum + model_mul(w, v);
        strobe_pair(w, v);
        if (disturb && row == 0 && k == 0) begin
          strobe_bias(rand_fixed());  // Early bias is dropped
          strobe_start(JOB_BUSY);     // START while busy is dropped
        end
      end
      if (disturb) strobe_pair(rand_fixed(), rand_fixed());  // Pair in BIAS_ADD
      if (gaps) random_gap();
      if (sweep) begin
        sweep_point(row, b, e);
      end else begin
        b = rand_fixed();
        e = model_row(sum, b);
      end
      strobe_bias(b);
      expect_row(e, row == int'(s.size_l) - 1);
    end
  endtask

  //////////////////////////////
  // Test sequence

  initial begin
    CLK            = 1'b0;
    RST            = 1'b1;
    START          = 1'b0;
    SIZE_IN        = '0;
    PAIR_IN_ENABLE = 1'b0;
    PAIR_IN        = '0;
    B_IN_ENABLE    = 1'b0;
    B_IN           = '0;
    want_en        = 1'b0;
    want_ready     = 1'b0;
    want_val       = '0;

    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // Quiet after reset with pairs while IDLE
    repeat (3) idle_cycle();
    repeat (3) strobe_pair(rand_fixed(), rand_fixed());
    repeat (2) idle_cycle();

    run_job(JOB_A, 1'b1, 1'b1, 1'b0);  // Gaps and ignored strobes
    run_job(JOB_B, 1'b0, 1'b0, 1'b1);  // Segment sweep
    run_job(JOB_C, 1'b0, 1'b0, 1'b0);  // Back to back
    run_job(JOB_D, 1'b0, 1'b0, 1'b0);  // R=0 job started right after the last bias

    repeat (3) strobe_pair(rand_fixed(), rand_fixed());  // IDLE while draining
    while (expect_q.size() != 0) idle_cycle();
    repeat (8) idle_cycle();

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: hw/forget_gate_top.sv
/*
 * Forget-gate vector unit
 * Controller, shared MAC engine and sigmoid stage in a three-row pipeline
 */

`timescale 1ns/1ns

module forget_gate_top import ntm_pkg::*; (
  input  logic          CLK,
  input  logic          RST,
  input  logic          START,
  input  gate_sizes_t   SIZE_IN,
  input  logic          PAIR_IN_ENABLE,
  input  operand_pair_t PAIR_IN,
  input  logic          B_IN_ENABLE,
  input  fixed_t        B_IN,
  output logic          F_OUT_ENABLE,
  output fixed_t        F_OUT,
  output logic          READY
);

  // Controller to MAC
  logic          acc_enable, acc_finish;
  operand_pair_t acc_pair;
  fixed_t        acc_bias;

  // MAC to sigmoid, sigmoid back to controller
  logic          acc_valid, sig_valid;
  fixed_t        acc_sum, sig_out;

  forget_gate_vector ctrl_i (
    .CLK(CLK), .RST(RST),
    .START(START), .SIZE_IN(SIZE_IN),
    .PAIR_IN_ENABLE(PAIR_IN_ENABLE), .PAIR_IN(PAIR_IN),
    .B_IN_ENABLE(B_IN_ENABLE), .B_IN(B_IN),
    .sig_valid(sig_valid), .sig_out(sig_out),
    .acc_enable(acc_enable), .acc_finish(acc_finish),
    .acc_pair(acc_pair), .acc_bias(acc_bias),
    .READY(READY), .F_OUT_ENABLE(F_OUT_ENABLE), .F_OUT(F_OUT)
  );

  dot_product_accumulator acc_i (
    .CLK(CLK), .RST(RST),
    .acc_enable(acc_enable), .acc_finish(acc_finish),
    .acc_pair(acc_pair), .acc_bias(acc_bias),
    .acc_valid(acc_valid), .acc_sum(acc_sum)
  );

  logistic_function sig_i (
    .CLK(CLK), .RST(RST),
    .acc_valid(acc_valid), .acc_sum(acc_sum),
    .sig_valid(sig_valid), .sig_out(sig_out)
  );

endmodule

// File: hw/forget_gate_vector.sv
/*
 * Forget-gate controller
 * Latches job sizes, counts operand pairs through the three products of
 * each row, drives the shared MAC engine and registers the sigmoid output
 */

`timescale 1ns/1ns

module forget_gate_vector import ntm_pkg::*; (
  input  logic          CLK,
  input  logic          RST,
  input  logic          START,
  input  gate_sizes_t   SIZE_IN,
  input  logic          PAIR_IN_ENABLE,
  input  operand_pair_t PAIR_IN,
  input  logic          B_IN_ENABLE,
  input  fixed_t        B_IN,
  input  logic          sig_valid,
  input  fixed_t        sig_out,
  output logic          acc_enable,
  output logic          acc_finish,
  output operand_pair_t acc_pair,
  output fixed_t        acc_bias,
  output logic          READY,
  output logic          F_OUT_ENABLE,
  output fixed_t        F_OUT
);

  // First phase at or after 'from' with any pairs to take
  function automatic gate_phase_e next_live(input gate_phase_e from,
                                            input gate_sizes_t s,
                                            input count_t      rlen);
    gate_phase_e p;
    p = from;
    if (p == INPUT_PRODUCT && s.size_x == '0) p = READ_PRODUCT;
    if (p == READ_PRODUCT && rlen == '0) p = HIDDEN_PRODUCT;
    return p;
  endfunction

  //////////////////////////////
  // State

  gate_phase_e phase;
  gate_sizes_t sizes;      // Sizes of the accepting job
  count_t      read_len;   // R*W
  count_t      elem_cnt;   // Pairs taken in this phase
  size_t       row_cnt;    // Row being accumulated
  size_t       out_cnt;    // Rows already output
  size_t       out_l;      // Row count of the job draining
  logic [1:0]  jobs;       // Jobs with outputs outstanding

  count_t      cur_len;
  gate_phase_e phase_after;
  count_t      start_rlen;
  logic        start_ok, in_product, pair_take, bias_take;
  logic        last_elem, last_row, out_wrap;

  //////////////////////////////
  // Decode

  assign start_rlen = count_t'(SIZE_IN.size_r) * count_t'(SIZE_IN.size_w);
  assign start_ok   = START && phase == IDLE && SIZE_IN.size_l != '0;  // Empty job ignored

  assign in_product = phase inside {INPUT_PRODUCT, READ_PRODUCT, HIDDEN_PRODUCT};
  assign pair_take  = PAIR_IN_ENABLE && in_product;
  assign bias_take  = B_IN_ENABLE && phase == BIAS_ADD;  // Early bias dropped

  always_comb begin
    cur_len     = '0;
    phase_after = BIAS_ADD;
    case (phase)
      INPUT_PRODUCT: begin
        cur_len     = count_t'(sizes.size_x);
        phase_after = next_live(READ_PRODUCT, sizes, read_len);
      end
      READ_PRODUCT: begin
        cur_len     = read_len;
        phase_after = HIDDEN_PRODUCT;  // L pairs in every accepted job
      end
      HIDDEN_PRODUCT: cur_len = count_t'(sizes.size_l);
      default: ;
    endcase
  end

  assign last_elem = elem_cnt == cur_len - 1'b1;
  assign last_row  = row_cnt == sizes.size_l - 1'b1;

  // MAC engine sees the operands straight from the ports
  assign acc_enable = pair_take;
  assign acc_finish = bias_take;
  assign acc_pair   = PAIR_IN;
  assign acc_bias   = B_IN;

  //////////////////////////////
  // Phase FSM

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= IDLE;
      sizes    <= '0;
      read_len <= '0;
      elem_cnt <= '0;
      row_cnt  <= '0;
    end else begin
      case (phase)
        IDLE: if (start_ok) begin
          sizes    <= SIZE_IN;
          read_len <= start_rlen;  // Multiply once per job
          elem_cnt <= '0;
          row_cnt  <= '0;
          phase    <= next_live(INPUT_PRODUCT, SIZE_IN, start_rlen);
        end
        INPUT_PRODUCT, READ_PRODUCT, HIDDEN_PRODUCT: if (pair_take) begin
          if (last_elem) begin
            elem_cnt <= '0;
            phase    <= phase_after;
          end else begin
            elem_cnt <= elem_cnt + 1'b1;
          end
        end
        BIAS_ADD: if (bias_take) begin
          if (last_row) begin
            phase <= IDLE;  // Free for a new START while rows drain
          end else begin
            row_cnt <= row_cnt + 1'b1;
            phase   <= next_live(INPUT_PRODUCT, sizes, read_len);
          end
        end
        default: phase <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Output and READY

  // Previous job's last row always leaves before the next job's first one
  assign out_wrap = sig_valid && out_cnt == out_l - 1'b1;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      F_OUT_ENABLE <= 1'b0;
      F_OUT        <= '0;
      READY        <= 1'b0;
      out_cnt      <= '0;
      out_l        <= '0;
      jobs         <= '0;
    end else begin
      F_OUT_ENABLE <= sig_valid;
      READY        <= out_wrap;  // With the last row's F_OUT_ENABLE
      if (sig_valid) F_OUT <= sig_out;
      jobs <= jobs + {1'b0, start_ok} - {1'b0, out_wrap};
      if (out_wrap) begin
        out_cnt <= '0;
        out_l   <= start_ok ? SIZE_IN.size_l : sizes.size_l;  // Next job if one started
      end else begin
        if (sig_valid) out_cnt <= out_cnt + 1'b1;
        if (start_ok && jobs == '0) out_l <= SIZE_IN.size_l;
      end
    end
  end

endmodule

// File: hw/logistic_function.sv
/*
 * Piecewise-linear sigmoid
 * Four segments on |z| with exact Q16.16 coefficients, mirrored for
 * negative inputs and registered with a valid strobe
 */

`timescale 1ns/1ns

`include "ntm_config.svh"

module logistic_function import ntm_pkg::*; (
  input  logic   CLK,
  input  logic   RST,
  input  logic   acc_valid,
  input  fixed_t acc_sum,
  output logic   sig_valid,
  output fixed_t sig_out
);

  //////////////////////////////
  // Segment constants

  localparam int F = `NTM_FRAC_BITS;

  localparam fixed_t Q_ONE    = fixed_t'(1) << F;
  localparam fixed_t Q_FIVE   = fixed_t'(5) << F;
  localparam fixed_t Q_2P375  = fixed_t'(19) << (F - 3);  // 19/8
  localparam fixed_t SLOPE_HI = fixed_t'(1) << (F - 5);   // 1/32
  localparam fixed_t OFFS_HI  = fixed_t'(27) << (F - 5);  // 27/32
  localparam fixed_t SLOPE_MD = fixed_t'(1) << (F - 3);   // 1/8
  localparam fixed_t OFFS_MD  = fixed_t'(5) << (F - 3);   // 5/8
  localparam fixed_t SLOPE_LO = fixed_t'(1) << (F - 2);   // 1/4
  localparam fixed_t OFFS_LO  = fixed_t'(1) << (F - 1);   // 1/2

  // a*c in Q16.16, truncated like the MAC
  function automatic fixed_t mul_q(input logic [`NTM_DATA_SIZE-1:0] a, input fixed_t c);
    logic [2*`NTM_DATA_SIZE-1:0] p;
    p = a * $unsigned(c);
    return fixed_t'(p[F +: `NTM_DATA_SIZE]);
  endfunction

  //////////////////////////////
  // Segment select

  logic                      neg;
  logic [`NTM_DATA_SIZE-1:0] mag;     // |z|, unsigned so -2^31 stays right
  fixed_t                    f_pos;   // f(|z|), always in [0.5, 1]
  fixed_t                    f_val;

  assign neg = acc_sum[`NTM_DATA_SIZE-1];
  assign mag = neg ? $unsigned(-acc_sum) : $unsigned(acc_sum);

  always_comb begin
    if (mag >= $unsigned(Q_FIVE))        f_pos = Q_ONE;  // Saturated
    else if (mag >= $unsigned(Q_2P375))  f_pos = mul_q(mag, SLOPE_HI) + OFFS_HI;
    else if (mag >= $unsigned(Q_ONE))    f_pos = mul_q(mag, SLOPE_MD) + OFFS_MD;
    else                                 f_pos = mul_q(mag, SLOPE_LO) + OFFS_LO;
  end

  assign f_val = neg ? Q_ONE - f_pos : f_pos;  // sigmoid(-a) = 1 - sigmoid(a)

  //////////////////////////////
  // Output register

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) sig_valid <= 1'b0;
    else     sig_valid <= acc_valid;
  end

  always_ff @(posedge CLK) begin
    if (acc_valid) sig_out <= f_val;
  end

endmodule

// File: hw/dot_product_accumulator.sv
/*
 * Fixed-point multiply-accumulate
 * Sums truncated Q16.16 products over a row, then adds the bias and
 * holds the row result for the logistic stage
 */

`timescale 1ns/1ns

`include "ntm_config.svh"

module dot_product_accumulator import ntm_pkg::*; (
  input  logic          CLK,
  input  logic          RST,
  input  logic          acc_enable,
  input  logic          acc_finish,
  input  operand_pair_t acc_pair,
  input  fixed_t        acc_bias,
  output logic          acc_valid,
  output fixed_t        acc_sum
);

  //////////////////////////////
  // Product

  logic signed [2*`NTM_DATA_SIZE-1:0] prod_full;  // Q32.32
  logic signed [2*`NTM_DATA_SIZE-1:0] prod_shift;
  fixed_t                             prod_q;     // Back to Q16.16
  fixed_t                             run_sum;    // Row total so far

  assign prod_full = $signed(acc_pair.weight) * $signed(acc_pair.value);

  // Arithmetic shift, so rounding goes toward minus infinity
  assign prod_shift = prod_full >>> `NTM_FRAC_BITS;
  assign prod_q     = prod_shift[`NTM_DATA_SIZE-1:0];  // Wraps mod 2^32

  //////////////////////////////
  // Running sum

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      run_sum   <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= acc_finish;  // One-cycle pulse per row
      if (acc_finish) begin
        run_sum <= '0;  // Next row may start next cycle
      end else if (acc_enable) begin
        run_sum <= run_sum + prod_q;
      end
    end
  end

  // Row result hold register
  always_ff @(posedge CLK) begin
    if (acc_finish) acc_sum <= run_sum + acc_bias;
  end

endmodule

// File: hw/ntm_pkg.sv
/*
 * NTM forget-gate types
 * Fixed-point value, job sizes, operand pairs and controller phases
 */

`include "ntm_config.svh"

package ntm_pkg;

  //////////////////////////////
  // Scalars

  // Signed Q16.16
  typedef logic signed [`NTM_DATA_SIZE-1:0] fixed_t;

  typedef logic [`NTM_SIZE_BITS-1:0]   size_t;   // One dimension
  typedef logic [2*`NTM_SIZE_BITS-1:0] count_t;  // Wide enough for R*W

  //////////////////////////////
  // Bundles

  // Job sizes, sampled on START
  typedef struct packed {
    size_t size_x;  // Input length X
    size_t size_w;  // Word width W
    size_t size_l;  // Row count L
    size_t size_r;  // Read heads R
  } gate_sizes_t;

  // One matrix element and its vector partner
  typedef struct packed {
    fixed_t weight;  // W, K or U element
    fixed_t value;   // x, r or h element
  } operand_pair_t;

  //////////////////////////////
  // Controller phases

  typedef enum logic [2:0] {
    IDLE,
    INPUT_PRODUCT,   // W*x
    READ_PRODUCT,    // K*r
    HIDDEN_PRODUCT,  // U*h
    BIAS_ADD         // Wait for b(l)
  } gate_phase_e;

endpackage

// File: hw/ntm_config.svh
/*
 * NTM forget-gate configuration
 * Fixed-point format and dimension widths shared by the package and RTL
 */

`ifndef NTM_CONFIG_SVH
`define NTM_CONFIG_SVH

//////////////////////////////
// Fixed-point format

// Full width of one Q16.16 value
`define NTM_DATA_SIZE 32

// Bits right of the binary point
`define NTM_FRAC_BITS 16

//////////////////////////////
// Dimensions

`define NTM_SIZE_BITS 8  // One of X, W, L, R

`endif
